//--- common/soc_pkg.sv
//****************************************
// SoC memory fabric shared definitions
// Bus widths, address map, memory depths,
// SRAM wait count and the fabric enums
//****************************************

package soc_pkg;

	// System bus
	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	typedef logic [BUS_DATA_W-1:0] bus_word_t;

	// External SRAM is 16 bits wide with half-word addresses
	localparam int SRAM_ADDR_W = 18;
	localparam int SRAM_DATA_W = 16;

	// Address map in word indices with exclusive upper bounds
	localparam logic [BUS_ADDR_W-1:0] RAM_BASE   = 32'h0001_0000;
	localparam logic [BUS_ADDR_W-1:0] RAM_LIMIT  = 32'h0002_0000;
	localparam logic [BUS_ADDR_W-1:0] SRAM_BASE  = 32'h1000_0000;
	localparam logic [BUS_ADDR_W-1:0] SRAM_LIMIT = 32'h2000_0000;
	localparam logic [BUS_ADDR_W-1:0] LED_BASE   = 32'h5000_0000;
	localparam logic [BUS_ADDR_W-1:0] LED_LIMIT  = 32'h5000_0010;

	// Storage sizes
	localparam int RAM_DEPTH  = 256;
	localparam int RAM_IDX_W  = $clog2(RAM_DEPTH);
	localparam int SRAM_DEPTH = 512;
	localparam int SRAM_IDX_W = $clog2(SRAM_DEPTH);

	// Wait states per SRAM half-word access
	localparam int SRAM_WAIT_CYCLES = 3;
	localparam int WAIT_CNT_W       = $clog2(SRAM_WAIT_CYCLES + 1);

	localparam int LED_W = 10;

	typedef logic [LED_W-1:0] led_t;

	typedef enum logic [1:0] {BR_IDLE, BR_LOW, BR_HIGH, BR_DONE} bridge_state_t;

	typedef enum logic [1:0] {TGT_RAM, TGT_SRAM, TGT_LED, TGT_NONE} target_t;

endpackage

//--- common/mem_bus_if.sv
//****************************************
// Request/ready memory bus
// One access in flight with a single ready
//****************************************

`timescale 1ns/1ps

interface mem_bus_if
	import soc_pkg::*;
#(
	parameter int ADDR_W = BUS_ADDR_W,
	parameter int DATA_W = BUS_DATA_W
);

	logic              request;
	logic              rw;      // 1 = write
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              ready;

	modport master (
		output request, rw, address, wdata,
		input  rdata, ready
	);

	modport slave (
		input  request, rw, address, wdata,
		output rdata, ready
	);

endinterface

//--- hdl/bus_decode.sv
//****************************************
// Bus address decoder
// Routes accesses to RAM, SRAM or LEDs and
// answers LED and unmapped accesses itself
//****************************************

`timescale 1ns/1ps

module bus_decode
	import soc_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_rst,
	input  logic                  i_bus_request,
	input  logic                  i_bus_rw,
	input  logic [BUS_ADDR_W-1:0] i_bus_address,
	input  bus_word_t             i_bus_wdata,
	output bus_word_t             o_bus_rdata,
	output logic                  o_bus_ready,
	mem_bus_if.master             ram,
	mem_bus_if.master             bridge,
	output led_t                  o_ledr
);

	target_t tgt;
	logic    local_req;
	logic    local_fire;
	logic    local_ready;
	logic    local_served;
	led_t    led_q;

	always_comb begin
		if (i_bus_address >= RAM_BASE && i_bus_address < RAM_LIMIT)
			tgt = TGT_RAM;
		else if (i_bus_address >= SRAM_BASE && i_bus_address < SRAM_LIMIT)
			tgt = TGT_SRAM;
		else if (i_bus_address >= LED_BASE && i_bus_address < LED_LIMIT)
			tgt = TGT_LED;
		else
			tgt = TGT_NONE;
	end

	// Targets see window offsets only
	assign ram.request    = i_bus_request && (tgt == TGT_RAM);
	assign ram.rw         = i_bus_rw;
	assign ram.address    = i_bus_address - RAM_BASE;
	assign ram.wdata      = i_bus_wdata;

	assign bridge.request = i_bus_request && (tgt == TGT_SRAM);
	assign bridge.rw      = i_bus_rw;
	assign bridge.address = i_bus_address - SRAM_BASE;
	assign bridge.wdata   = i_bus_wdata;

	// LED and unmapped accesses are answered here
	assign local_req  = i_bus_request && (tgt == TGT_LED || tgt == TGT_NONE);
	assign local_fire = local_req && !local_ready && !local_served;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			local_ready  <= 1'b0;
			local_served <= 1'b0;
			led_q        <= '0;
		end else begin
			local_ready  <= local_fire;
			// Hold off a second ready until the request drops
			local_served <= local_req && (local_served || local_ready);
			if (local_fire && i_bus_rw && tgt == TGT_LED)
				led_q <= i_bus_wdata[LED_W-1:0];
		end
	end

	assign o_ledr = led_q;

	// Return path
	always_comb begin
		case (tgt)
			TGT_RAM: begin
				o_bus_rdata = ram.rdata;
				o_bus_ready = ram.ready;
			end
			TGT_SRAM: begin
				o_bus_rdata = bridge.rdata;
				o_bus_ready = bridge.ready;
			end
			TGT_LED: begin
				o_bus_rdata = {{(BUS_DATA_W-LED_W){1'b0}}, led_q};
				o_bus_ready = local_ready;
			end
			default: begin
				o_bus_rdata = '0;
				o_bus_ready = local_ready;
			end
		endcase
	end

endmodule

//--- hdl/block_ram.sv
//****************************************
// Word-addressed on-chip block RAM
// Ready one cycle after the request
//****************************************

`timescale 1ns/1ps

module block_ram
	import soc_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_rst,
	mem_bus_if.slave  bus
);

	bus_word_t            mem [RAM_DEPTH];
	bus_word_t            rdata_q;
	logic [RAM_IDX_W-1:0] idx;
	logic                 fire;
	logic                 ready_q;
	logic                 served;

	// Index wraps inside the window
	assign idx  = bus.address[RAM_IDX_W-1:0];
	assign fire = bus.request && !ready_q && !served;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready_q <= 1'b0;
			served  <= 1'b0;
		end else begin
			ready_q <= fire;
			served  <= bus.request && (served || ready_q);
		end
	end

	always_ff @(posedge i_clock) begin
		if (fire && bus.rw)
			mem[idx] <= bus.wdata;
		if (fire)
			rdata_q <= mem[idx];
	end

	assign bus.rdata = rdata_q;
	assign bus.ready = ready_q;

endmodule

//--- sram/sram_wait_timer.sv
//****************************************
// SRAM wait-state timer
// Down-counter with a one-cycle done
//****************************************

`timescale 1ns/1ps

module sram_wait_timer
	import soc_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_start,
	output logic o_done
);

	logic [WAIT_CNT_W-1:0] count;
	logic                  running;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			count   <= '0;
			running <= 1'b0;
		end else if (i_start) begin
			count   <= WAIT_CNT_W'(SRAM_WAIT_CYCLES);
			running <= 1'b1;
		end else if (running) begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	assign o_done = running && (count == '0);

endmodule

//--- sram/sram16_store.sv
//****************************************
// 16-bit SRAM model
// Half-word storage paced by wait states
//****************************************

`timescale 1ns/1ps

module sram16_store
	import soc_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_rst,
	mem_bus_if.slave  bus
);

	logic [SRAM_DATA_W-1:0] mem [SRAM_DEPTH];
	logic [SRAM_IDX_W-1:0]  idx;
	logic                   start;
	logic                   done;
	logic                   pending;
	logic                   served;

	assign idx   = bus.address[SRAM_IDX_W-1:0];
	assign start = bus.request && !pending && !served;

	sram_wait_timer u_wait_timer (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_start (start),
		.o_done  (done)
	);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pending <= 1'b0;
			served  <= 1'b0;
		end else begin
			if (start)
				pending <= 1'b1;
			else if (done)
				pending <= 1'b0;
			// Cleared once the master lets go of the request
			served <= bus.request && (served || done);
		end
	end

	// Write lands at the end of the ready cycle
	always_ff @(posedge i_clock) begin
		if (done && bus.rw)
			mem[idx] <= bus.wdata;
	end

	// Asynchronous-style read that stays valid while ready is high
	assign bus.rdata = mem[idx];
	assign bus.ready = done;

endmodule

//--- sram/mem_16_to_32.sv
//****************************************
// 32-bit to 16-bit SRAM bridge
// Splits each word into low then high
// half-word accesses on the SRAM bus
//****************************************

`timescale 1ns/1ps

module mem_16_to_32
	import soc_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_rst,
	mem_bus_if.slave  host,
	mem_bus_if.master sram
);

	bridge_state_t          state;
	logic                   sram_req;
	logic                   sram_rw;
	logic [SRAM_ADDR_W-1:0] sram_addr;
	logic [SRAM_DATA_W-1:0] sram_wdata;
	logic                   host_ready;
	bus_word_t              rdata_q;
	logic [SRAM_ADDR_W-2:0] word_idx;

	// Word n covers half-words 2n and 2n+1
	assign word_idx = host.address[SRAM_ADDR_W-2:0];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state      <= BR_IDLE;
			sram_req   <= 1'b0;
			host_ready <= 1'b0;
		end else begin
			host_ready <= 1'b0;
			case (state)
				BR_IDLE: begin
					if (host.request) begin
						sram_req <= 1'b1;
						state    <= BR_LOW;
					end
				end
				BR_LOW: begin
					// Request drops for a cycle between the halves
					if (sram.ready) begin
						sram_req <= 1'b0;
						state    <= BR_HIGH;
					end
				end
				BR_HIGH: begin
					if (sram.ready) begin
						sram_req   <= 1'b0;
						host_ready <= 1'b1;
						state      <= BR_DONE;
					end else begin
						sram_req <= 1'b1;
					end
				end
				BR_DONE: begin
					if (!host.request)
						state <= BR_IDLE;
				end
				default: state <= BR_IDLE;
			endcase
		end
	end

	// Half-word payload and read assembly
	always_ff @(posedge i_clock) begin
		case (state)
			BR_IDLE: begin
				sram_rw    <= host.rw;
				sram_addr  <= {word_idx, 1'b0};
				sram_wdata <= host.wdata[SRAM_DATA_W-1:0];
			end
			BR_LOW: begin
				if (sram.ready) begin
					rdata_q[SRAM_DATA_W-1:0] <= sram.rdata;
					sram_addr  <= {word_idx, 1'b1};
					sram_wdata <= host.wdata[2*SRAM_DATA_W-1:SRAM_DATA_W];
				end
			end
			BR_HIGH: begin
				if (sram.ready)
					rdata_q[2*SRAM_DATA_W-1:SRAM_DATA_W] <= sram.rdata;
			end
			default: ;
		endcase
	end

	assign sram.request = sram_req;
	assign sram.rw      = sram_rw;
	assign sram.address = sram_addr;
	assign sram.wdata   = sram_wdata;

	assign host.rdata = rdata_q;
	assign host.ready = host_ready;

endmodule

//--- hdl/soc_mem_top.sv
//****************************************
// SoC memory and I/O bus fabric
// Decoder, block RAM, SRAM bridge and LEDs
//****************************************

`timescale 1ns/1ps

module soc_mem_top
	import soc_pkg::*;
(
	input  logic                  i_clock,
	input  logic                  i_rst,
	input  logic                  i_bus_request,
	input  logic                  i_bus_rw,
	input  logic [BUS_ADDR_W-1:0] i_bus_address,
	input  bus_word_t             i_bus_wdata,
	output bus_word_t             o_bus_rdata,
	output logic                  o_bus_ready,
	output led_t                  o_ledr
);

	mem_bus_if #(.ADDR_W(BUS_ADDR_W), .DATA_W(BUS_DATA_W)) ram_bus ();
	mem_bus_if #(.ADDR_W(BUS_ADDR_W), .DATA_W(BUS_DATA_W)) bridge_bus ();
	// Half-word side of the bridge
	mem_bus_if #(.ADDR_W(SRAM_ADDR_W), .DATA_W(SRAM_DATA_W)) sram_bus ();

	bus_decode u_bus_decode (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_bus_request (i_bus_request),
		.i_bus_rw      (i_bus_rw),
		.i_bus_address (i_bus_address),
		.i_bus_wdata   (i_bus_wdata),
		.o_bus_rdata   (o_bus_rdata),
		.o_bus_ready   (o_bus_ready),
		.ram           (ram_bus.master),
		.bridge        (bridge_bus.master),
		.o_ledr        (o_ledr)
	);

	block_ram u_block_ram (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.bus     (ram_bus.slave)
	);

	mem_16_to_32 u_mem_16_to_32 (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.host    (bridge_bus.slave),
		.sram    (sram_bus.master)
	);

	sram16_store u_sram16_store (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.bus     (sram_bus.slave)
	);

endmodule

//--- tests/tb_soc_mem_top.sv
//****************************************
// Testbench for the SoC memory fabric
// Directed RAM, SRAM, LED and unmapped
// tests plus a random mixed run
//****************************************

`timescale 1ns/1ps

module tb_soc_mem_top
	import soc_pkg::*;
;

	localparam int RESET_CYCLES   = 10;
	localparam int ACCESS_LIMIT   = 40;
	localparam int SRAM_WORDS     = SRAM_DEPTH / 2;
	localparam int RANDOM_OPS     = 60;
	// Bus accesses issued by each test in order
	localparam int TOTAL_ACCESSES = 18 + 16 + 4 + 5 + RANDOM_OPS;
	localparam int WATCHDOG_CYCLES =
		2 * (RESET_CYCLES + TOTAL_ACCESSES * (ACCESS_LIMIT + 2));

	logic                  clock;
	logic                  rst;
	logic                  bus_request;
	logic                  bus_rw;
	logic [BUS_ADDR_W-1:0] bus_address;
	bus_word_t             bus_wdata;
	bus_word_t             bus_rdata;
	logic                  bus_ready;
	led_t                  ledr;

	bus_word_t ram_model  [RAM_DEPTH];
	bit        ram_valid  [RAM_DEPTH];
	bus_word_t sram_model [SRAM_WORDS];
	bit        sram_valid [SRAM_WORDS];

	int seed;
	int error_count;
	int errors_at_start;
	int pass_count;
	int fail_count;

	soc_mem_top u_soc_mem_top (
		.i_clock       (clock),
		.i_rst         (rst),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_rdata   (bus_rdata),
		.o_bus_ready   (bus_ready),
		.o_ledr        (ledr)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
		if (exp !== act) begin
			$display("mismatch %s expected 0x%08h actual 0x%08h", name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_led(input string name, input led_t exp, input led_t act);
		if (exp !== act) begin
			$display("mismatch %s expected 0x%03h actual 0x%03h", name, exp, act);
			error_count++;
		end
	endtask

	// One access with request held until ready is seen on a falling edge
	task automatic bus_access(input logic rw, input logic [BUS_ADDR_W-1:0] addr,
		input bus_word_t wdata, output bus_word_t rdata);
		int waited;
		@(negedge clock);
		bus_request = 1'b1;
		bus_rw      = rw;
		bus_address = addr;
		bus_wdata   = wdata;
		waited      = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!bus_ready && waited < ACCESS_LIMIT);
		if (!bus_ready) begin
			$display("timeout: no ready for access to address 0x%08h", addr);
			error_count++;
		end
		rdata       = bus_rdata;
		bus_request = 1'b0;
	endtask

	task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input bus_word_t data);
		bus_word_t unused;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output bus_word_t data);
		bus_access(1'b0, addr, '0, data);
	endtask

	// RAM repeats every RAM_DEPTH words, SRAM every SRAM_DEPTH/2 words
	task automatic ram_write(input int offs, input bus_word_t data);
		bus_write(RAM_BASE + BUS_ADDR_W'(offs), data);
		ram_model[offs % RAM_DEPTH] = data;
		ram_valid[offs % RAM_DEPTH] = 1'b1;
	endtask

	task automatic ram_check(input string name, input int offs);
		bus_word_t got;
		bus_read(RAM_BASE + BUS_ADDR_W'(offs), got);
		check_word(name, ram_model[offs % RAM_DEPTH], got);
	endtask

	task automatic sram_write(input int offs, input bus_word_t data);
		bus_write(SRAM_BASE + BUS_ADDR_W'(offs), data);
		sram_model[offs % SRAM_WORDS] = data;
		sram_valid[offs % SRAM_WORDS] = 1'b1;
	endtask

	task automatic sram_check(input string name, input int offs);
		bus_word_t got;
		bus_read(SRAM_BASE + BUS_ADDR_W'(offs), got);
		check_word(name, sram_model[offs % SRAM_WORDS], got);
	endtask

	task automatic start_test();
		errors_at_start = error_count;
	endtask

	task automatic finish_test(input string name);
		if (error_count == errors_at_start) begin
			pass_count++;
			$display("test %s: pass", name);
		end else begin
			fail_count++;
			$display("test %s: FAIL with %0d errors", name, error_count - errors_at_start);
		end
	endtask

	task automatic test_reset_state();
		start_test();
		if (bus_ready !== 1'b0) begin
			$display("reset_state: o_bus_ready is not low after reset");
			error_count++;
		end
		check_led("reset_state", '0, ledr);
		finish_test("reset_state");
	endtask

	task automatic test_ram();
		start_test();
		for (int i = 0; i < 8; i++)
			ram_write(i * 3, 32'hC0DE_0000 + bus_word_t'(i * 32'h0101_0111));
		for (int i = 0; i < 8; i++)
			ram_check("ram_rw", i * 3);
		ram_write(5 + RAM_DEPTH, 32'hA11A_5005);
		ram_check("ram_alias", 5);
		finish_test("ram");
	endtask

	task automatic test_sram();
		start_test();
		// Differing halves catch swapped or dropped half-words
		sram_write(0, 32'h1234_ABCD);
		sram_write(1, 32'hFFFF_0000);
		sram_write(2, 32'h0000_FFFF);
		sram_write(3, 32'hDEAD_BEEF);
		sram_write(4, 32'h8001_7FFE);
		sram_write(5, 32'h5A5A_A5A5);
		sram_write(6, 32'h0F0F_F0F0);
		sram_write(7, 32'hCAFE_1357);
		for (int i = 0; i < 8; i++)
			sram_check("sram_rw", i);
		finish_test("sram");
	endtask

	task automatic test_led();
		bus_word_t got;
		bus_word_t data;
		start_test();
		data = 32'hABCD_E3A5;
		bus_write(LED_BASE, data);
		check_led("led_write", led_t'(data), ledr);
		bus_read(LED_BASE, got);
		check_word("led_read", bus_word_t'(led_t'(data)), got);
		data = 32'h0000_0C42;
		bus_write(LED_BASE + 1, data);
		check_led("led_write", led_t'(data), ledr);
		bus_read(LED_BASE, got);
		check_word("led_read", bus_word_t'(led_t'(data)), got);
		finish_test("led");
	endtask

	task automatic test_unmapped();
		bus_word_t got;
		led_t      led_before;
		start_test();
		led_before = ledr;
		bus_read(32'h3000_0000, got);
		check_word("unmapped_read", '0, got);
		bus_write(32'h3000_0000, 32'hBAD0_BAD0);
		// A stray write would wrap onto word 0 of either memory
		ram_check("unmapped_ram", 0);
		sram_check("unmapped_sram", 0);
		bus_read(LED_BASE, got);
		check_word("unmapped_led", bus_word_t'(led_before), got);
		finish_test("unmapped");
	endtask

	task automatic test_random();
		int        offs;
		bit        use_sram;
		bit        do_write;
		bus_word_t data;
		start_test();
		for (int i = 0; i < RANDOM_OPS; i++) begin
			use_sram = ($unsigned($random(seed)) % 2) == 1;
			offs     = int'($unsigned($random(seed)) % 24);
			do_write = ($unsigned($random(seed)) % 2) == 0;
			data     = $random(seed);
			if (use_sram) begin
				if (do_write || !sram_valid[offs])
					sram_write(offs, data);
				else
					sram_check("random_sram", offs);
			end else begin
				if (do_write || !ram_valid[offs])
					ram_write(offs, data);
				else
					ram_check("random_ram", offs);
			end
		end
		finish_test("random");
	endtask

	initial begin
		seed        = 98;
		error_count = 0;
		pass_count  = 0;
		fail_count  = 0;
		rst         = 1'b1;
		bus_request = 1'b0;
		bus_rw      = 1'b0;
		bus_address = '0;
		bus_wdata   = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		@(negedge clock);

		test_reset_state();
		test_ram();
		test_sram();
		test_led();
		test_unmapped();
		test_random();

		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- sources.f
common/soc_pkg.sv
common/mem_bus_if.sv
hdl/bus_decode.sv
hdl/block_ram.sv
sram/sram_wait_timer.sv
sram/sram16_store.sv
sram/mem_16_to_32.sv
hdl/soc_mem_top.sv
tests/tb_soc_mem_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SoC memory fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_soc_mem_top -o sim_tb \
	> build.log 2>&1 \
	|| { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "all tests passed" sim.log && exit 0 || exit 1
